/* flist.f */
+incdir+include
rtl/switch_pkg.sv
rtl/flow_pkg.sv
rtl/hdr_link_if.sv
rtl/hdr_latch.sv
rtl/match_action_stage.sv
rtl/flow_table.sv
rtl/switch_top.sv
verif/tb_switch.sv

/* run.sh */
#!/bin/sh
# build and run the switch testbench with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module tb_switch -f flist.f -o tb_switch_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_switch_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Test failed" "$LOG"; then
    echo "simulation reported a failure, see $LOG"
    exit 1
fi

echo "simulation passed"
exit 0

/* include/tb_model.svh */
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// shadow of both banks, kept in step with controller writes
flow_word_t shadow_tbl [2][1 << TBL_IDX_W];

// galois lfsr state
logic [15:0] lfsr_state = 16'd15915;

// one stage against one bank
function automatic hdr_t model_stage(input hdr_t h, input int unsigned key_off,
                                     input int unsigned bank);
    flow_word_t e;
    hdr_t       r;
    r = h;
    e = shadow_tbl[bank][h[key_off]];
    if (e.entry.valid) begin
        r[e.entry.set_off] = e.entry.set_val;
    end
    return r;
endfunction

// stage 1 keys on the stage 0 result
function automatic hdr_t model_pipeline(input hdr_t h, input int unsigned key_off0,
                                        input int unsigned key_off1);
    hdr_t mid;
    mid = model_stage(h, key_off0, 0);
    return model_stage(mid, key_off1, 1);
endfunction

// one lfsr step per bit returned
function automatic logic [31:0] lfsr_rand(input int unsigned nbits);
    logic [31:0] v;
    v = '0;
    for (int unsigned i = 0; i < nbits; i++) begin
        v = {v[30:0], lfsr_state[0]};
        lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 16'hB400) : (lfsr_state >> 1);
    end
    return v;
endfunction

`endif

/* verif/tb_switch.sv */
`timescale 1ns/1ps

module tb_switch import switch_pkg::*, flow_pkg::*; ();

    localparam int unsigned CLK_PERIOD = 100;
    localparam int unsigned KEY0       = 2;
    localparam int unsigned KEY1       = 5;
    localparam int unsigned N_RAND     = 40;
    localparam int unsigned TBL_WORDS  = 1 << CTRL_ADDR_W;
    // two full table fills and a few accesses at 3 cycles, 12 cycles per header
    localparam int unsigned TEST_CYCLES = 20 + 3 * (2 * TBL_WORDS + 24) + 12 * (N_RAND + 12);

    logic                   clk;
    logic                   rst_n_i;
    logic                   sw_wr_i;
    hdr_t                   sw_pkt_hdr_i;
    logic                   sw_in_empty_o;
    logic                   sw_rd_i;
    hdr_t                   sw_pkt_hdr_o;
    logic                   sw_out_empty_o;
    logic                   ctrl_mem_ce_i;
    logic                   ctrl_mem_we_i;
    logic [CTRL_ADDR_W-1:0] ctrl_mem_addr_i;
    logic [DATA_W-1:0]      ctrl_mem_data_i;
    logic [DATA_W-1:0]      ctrl_mem_data_o;
    logic                   ctrl_mem_ready_o;

    hdr_t        exp_q [$];
    logic        drain_en    = 1'b1;
    logic        gap_en      = 1'b0;
    int unsigned err_count   = 0;
    int unsigned err_mark    = 0;
    int unsigned check_count = 0;
    int unsigned test_count  = 0;
    int unsigned test_errs   = 0;

    `include "tb_model.svh"

    switch_top u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        repeat (TEST_CYCLES * 20) @(posedge clk);
        $display("watchdog expired after %0d cycles, the switch stopped answering",
                 TEST_CYCLES * 20);
        $display("Test failed");
        $finish;
    end

    task automatic finish_test(input string name);
        test_count++;
        if (err_count == err_mark) begin
            $display("test %0d %s: pass", test_count, name);
        end else begin
            test_errs++;
            $display("test %0d %s: %0d errors", test_count, name, err_count - err_mark);
        end
        err_mark = err_count;
    endtask

    task automatic expect_level(input string name, input logic got, input logic exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("Error: %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic verify_hdr(input string name, input hdr_t got, input hdr_t exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("Error: %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic compare_word(input string name, input flow_word_t got,
                                input flow_word_t exp);
        check_count++;
        if (got.raw !== exp.raw) begin
            err_count++;
            $display("Error: %s got %h expected %h", name, got.raw, exp.raw);
        end
    endtask

    // enable held until ready, reads checked against the shadow banks
    task automatic ctrl_access(input logic we, input logic [CTRL_ADDR_W-1:0] addr,
                               input logic [DATA_W-1:0] wdata);
        int unsigned n;
        flow_word_t  got;
        n = 0;
        @(posedge clk);
        #1;
        ctrl_mem_ce_i   = 1'b1;
        ctrl_mem_we_i   = we;
        ctrl_mem_addr_i = addr;
        ctrl_mem_data_i = wdata;
        do begin
            @(posedge clk);
            #1;
            n++;
        end while (!ctrl_mem_ready_o && n < 50);
        if (!ctrl_mem_ready_o) begin
            err_count++;
            $display("controller access to address %h never got ready", addr);
        end
        got.raw       = ctrl_mem_data_o;
        ctrl_mem_ce_i = 1'b0;
        ctrl_mem_we_i = 1'b0;
        if (we) begin
            shadow_tbl[addr[CTRL_ADDR_W-1]][addr[TBL_IDX_W-1:0]].raw = wdata;
        end else begin
            compare_word("ctrl_mem_data_o", got,
                         shadow_tbl[addr[CTRL_ADDR_W-1]][addr[TBL_IDX_W-1:0]]);
        end
    endtask

    task automatic send_hdr(input hdr_t h);
        int unsigned n;
        n = 0;
        do begin
            @(posedge clk);
            #1;
            n++;
        end while (!sw_in_empty_o && n < 100);
        if (!sw_in_empty_o) begin
            err_count++;
            $display("input latch stayed full, header %h not sent", h);
        end else begin
            exp_q.push_back(model_pipeline(h, KEY0, KEY1));
            sw_wr_i      = 1'b1;
            sw_pkt_hdr_i = h;
            @(posedge clk);
            #1;
            sw_wr_i = 1'b0;
        end
    endtask

    task automatic wait_drain();
        int unsigned n;
        n = 0;
        while (exp_q.size() != 0 && n < 2000) begin
            @(posedge clk);
            n++;
        end
        if (exp_q.size() != 0) begin
            err_count++;
            $display("%0d headers never left the switch", exp_q.size());
            exp_q.delete();
        end
    endtask

    // output side, compares against the oldest expected header
    initial begin
        int unsigned gap;
        hdr_t        exp;
        gap     = 0;
        sw_rd_i = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            sw_rd_i = 1'b0;
            if (gap > 0) begin
                gap--;
            end else if (drain_en && rst_n_i && !sw_out_empty_o) begin
                if (exp_q.size() == 0) begin
                    err_count++;
                    $display("header %h came out with none expected", sw_pkt_hdr_o);
                end else begin
                    exp = exp_q.pop_front();
                    verify_hdr("sw_pkt_hdr_o", sw_pkt_hdr_o, exp);
                end
                sw_rd_i = 1'b1;
                if (gap_en) begin
                    gap = lfsr_rand(2);
                end
            end
        end
    end

    initial begin
        hdr_t                   h;
        hdr_t                   rand_hdr [N_RAND];
        logic [CTRL_ADDR_W-1:0] a;
        rst_n_i         = 1'b0;
        sw_wr_i         = 1'b0;
        sw_pkt_hdr_i    = '0;
        ctrl_mem_ce_i   = 1'b0;
        ctrl_mem_we_i   = 1'b0;
        ctrl_mem_addr_i = '0;
        ctrl_mem_data_i = '0;
        repeat (10) @(posedge clk);
        #1;
        rst_n_i = 1'b1;
        @(posedge clk);
        #1;
        expect_level("sw_in_empty_o", sw_in_empty_o, 1'b1);
        expect_level("sw_out_empty_o", sw_out_empty_o, 1'b1);
        expect_level("ctrl_mem_ready_o", ctrl_mem_ready_o, 1'b0);
        finish_test("reset state");

        // addresses in both banks, reserved bits nonzero
        for (int i = 0; i < 8; i++) begin
            ctrl_access(1'b1, CTRL_ADDR_W'(i * 71 + 5),
                        32'h3A5C_F0E1 ^ DATA_W'(i * 32'h1357_9BDF));
        end
        for (int i = 0; i < 8; i++) begin
            ctrl_access(1'b0, CTRL_ADDR_W'(i * 71 + 5), '0);
        end
        finish_test("controller write and read");

        // invalid fill, pattern from the whole address
        for (int i = 0; i < TBL_WORDS; i++) begin
            a = CTRL_ADDR_W'(i);
            ctrl_access(1'b1, a, {1'b0, a, a, a, a[3:0]});
        end
        for (int k = 0; k < 6; k++) begin
            for (int j = 0; j < HDR_LEN; j++) begin
                h[j] = BYTE_W'(k * 17 + j * 29);
            end
            send_hdr(h);
        end
        wait_drain();
        finish_test("all entries invalid");

        // bank 0 hits on 11 and 20, bank 1 on 42 and 33
        ctrl_access(1'b1, 9'h011, 32'h8000_0542);
        ctrl_access(1'b1, 9'h020, 32'h8000_0277);
        ctrl_access(1'b1, 9'h142, 32'h8000_09A5);
        ctrl_access(1'b1, 9'h133, 32'h8000_00EE);
        for (int k = 0; k < 3; k++) begin
            for (int j = 0; j < HDR_LEN; j++) begin
                h[j] = BYTE_W'(j * 5 + k);
            end
            h[KEY0] = (k == 0) ? 8'h11 : ((k == 1) ? 8'h20 : 8'h05);
            h[KEY1] = (k == 0) ? 8'h00 : 8'h33;
            send_hdr(h);
        end
        wait_drain();
        finish_test("valid entries rewrite");

        @(negedge clk);
        drain_en = 1'b0;
        for (int k = 0; k < 3; k++) begin
            for (int j = 0; j < HDR_LEN; j++) begin
                h[j] = BYTE_W'(j * 7 + k * 3);
            end
            h[KEY0] = (k == 1) ? 8'h20 : 8'h11;
            send_hdr(h);
        end
        repeat (10) @(posedge clk);
        #1;
        expect_level("sw_in_empty_o", sw_in_empty_o, 1'b0);
        @(negedge clk);
        drain_en = 1'b1;
        wait_drain();
        finish_test("back-pressure");

        for (int i = 0; i < TBL_WORDS; i++) begin
            ctrl_access(1'b1, CTRL_ADDR_W'(i), lfsr_rand(DATA_W));
        end
        // headers drawn before the reader starts drawing gaps
        for (int k = 0; k < N_RAND; k++) begin
            for (int j = 0; j < HDR_LEN; j++) begin
                rand_hdr[k][j] = BYTE_W'(lfsr_rand(BYTE_W));
            end
        end
        @(negedge clk);
        gap_en = 1'b1;
        for (int k = 0; k < N_RAND; k++) begin
            send_hdr(rand_hdr[k]);
        end
        wait_drain();
        gap_en = 1'b0;
        finish_test("randomized traffic");

        $display("tests %0d, tests with errors %0d, checks %0d, errors %0d",
                 test_count, test_errs, check_count, err_count);
        if (err_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* rtl/switch_top.sv */
`timescale 1ns/1ps

module switch_top import switch_pkg::*, flow_pkg::*; #(
    parameter int unsigned STAGE0_KEY_OFF = 2,
    parameter int unsigned STAGE1_KEY_OFF = 5
) (
    input  logic                   clk,
    input  logic                   rst_n_i,
    // switch input
    input  logic                   sw_wr_i,
    input  hdr_t                   sw_pkt_hdr_i,
    output logic                   sw_in_empty_o,
    // switch output
    input  logic                   sw_rd_i,
    output hdr_t                   sw_pkt_hdr_o,
    output logic                   sw_out_empty_o,
    // controller access to the flow table
    input  logic                   ctrl_mem_ce_i,
    input  logic                   ctrl_mem_we_i,
    input  logic [CTRL_ADDR_W-1:0] ctrl_mem_addr_i,
    input  logic [DATA_W-1:0]      ctrl_mem_data_i,
    output logic [DATA_W-1:0]      ctrl_mem_data_o,
    output logic                   ctrl_mem_ready_o
);

    hdr_link_if link0 ();
    hdr_link_if link1 ();
    hdr_link_if link2 ();

    logic [1:0]                lookup_req;
    logic [1:0][TBL_IDX_W-1:0] lookup_idx;
    flow_word_t [1:0]          entry;

    // pipeline ends
    assign link0.wr       = sw_wr_i;
    assign link0.hdr      = sw_pkt_hdr_i;
    assign sw_in_empty_o  = link0.empty;
    assign link2.rd       = sw_rd_i;
    assign sw_pkt_hdr_o   = link2.rd_hdr;
    assign sw_out_empty_o = link2.empty;

    hdr_latch u_latch0 (.clk(clk), .rst_n_i(rst_n_i), .link(link0));
    hdr_latch u_latch1 (.clk(clk), .rst_n_i(rst_n_i), .link(link1));
    hdr_latch u_latch2 (.clk(clk), .rst_n_i(rst_n_i), .link(link2));

    // stage 0 uses bank 0
    match_action_stage #(
        .KEY_OFF(STAGE0_KEY_OFF)
    ) u_stage0 (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .in_link      (link0),
        .out_link     (link1),
        .lookup_req_o (lookup_req[0]),
        .lookup_idx_o (lookup_idx[0]),
        .entry_i      (entry[0])
    );

    // stage 1 uses bank 1
    match_action_stage #(
        .KEY_OFF(STAGE1_KEY_OFF)
    ) u_stage1 (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .in_link      (link1),
        .out_link     (link2),
        .lookup_req_o (lookup_req[1]),
        .lookup_idx_o (lookup_idx[1]),
        .entry_i      (entry[1])
    );

    flow_table u_flow_table (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .lookup_req_i (lookup_req),
        .lookup_idx_i (lookup_idx),
        .entry_o      (entry),
        .ctrl_ce_i    (ctrl_mem_ce_i),
        .ctrl_we_i    (ctrl_mem_we_i),
        .ctrl_addr_i  (ctrl_mem_addr_i),
        .ctrl_data_i  (ctrl_mem_data_i),
        .ctrl_data_o  (ctrl_mem_data_o),
        .ctrl_ready_o (ctrl_mem_ready_o)
    );

endmodule

/* rtl/flow_table.sv */
`timescale 1ns/1ps

module flow_table import flow_pkg::*; (
    input  logic                       clk,
    input  logic                       rst_n_i,
    input  logic [1:0]                 lookup_req_i,
    input  logic [1:0][TBL_IDX_W-1:0]  lookup_idx_i,
    output flow_word_t [1:0]           entry_o,
    input  logic                       ctrl_ce_i,
    input  logic                       ctrl_we_i,
    input  logic [CTRL_ADDR_W-1:0]     ctrl_addr_i,
    input  logic [DATA_W-1:0]          ctrl_data_i,
    output logic [DATA_W-1:0]          ctrl_data_o,
    output logic                       ctrl_ready_o
);

    localparam int unsigned DEPTH = 1 << TBL_IDX_W;

    logic                 ctrl_bank;
    logic [TBL_IDX_W-1:0] ctrl_idx;
    logic                 ctrl_go;
    logic                 done_q;
    logic                 ready_q;
    logic                 bank_q;

    assign ctrl_bank = ctrl_addr_i[CTRL_ADDR_W-1];
    assign ctrl_idx  = ctrl_addr_i[TBL_IDX_W-1:0];

    // stage lookups own the bank, controller waits for a free cycle
    assign ctrl_go = ctrl_ce_i && !done_q && !lookup_req_i[ctrl_bank];

    for (genvar b = 0; b < 2; b++) begin : g_bank
        flow_word_t mem [DEPTH];
        flow_word_t rdata_q;
        logic       sel;

        assign sel = ctrl_go && (ctrl_bank == 1'(b));

        // one read port, shared by lookup and controller read
        always_ff @(posedge clk) begin
            if (lookup_req_i[b]) begin
                rdata_q <= mem[lookup_idx_i[b]];
            end else if (sel) begin
                if (ctrl_we_i) begin
                    mem[ctrl_idx].raw <= ctrl_data_i;
                end else begin
                    rdata_q <= mem[ctrl_idx];
                end
            end
        end

        assign entry_o[b] = rdata_q;
    end

    // done holds off a second access until the enable drops
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            done_q  <= 1'b0;
            ready_q <= 1'b0;
            bank_q  <= 1'b0;
        end else begin
            ready_q <= ctrl_go;
            if (ctrl_go) begin
                done_q <= 1'b1;
                bank_q <= ctrl_bank;
            end else if (!ctrl_ce_i) begin
                done_q <= 1'b0;
            end
        end
    end

    // read data of the bank last served for the controller
    assign ctrl_data_o  = entry_o[bank_q].raw;
    assign ctrl_ready_o = ready_q;

endmodule

/* rtl/match_action_stage.sv */
`timescale 1ns/1ps

module match_action_stage import switch_pkg::*, flow_pkg::*; #(
    parameter int unsigned KEY_OFF = 0
) (
    input  logic                 clk,
    input  logic                 rst_n_i,
    hdr_link_if.consumer         in_link,
    hdr_link_if.producer         out_link,
    output logic                 lookup_req_o,
    output logic [TBL_IDX_W-1:0] lookup_idx_o,
    input  flow_word_t           entry_i
);

    localparam logic [1:0] S_IDLE  = 2'd0;
    localparam logic [1:0] S_WAIT  = 2'd1;
    localparam logic [1:0] S_WRITE = 2'd2;

    logic [1:0] state_q;
    logic [1:0] state_d;
    logic       start;
    hdr_t       hdr_q;
    hdr_t       hdr_rewr;

    // take a header only when the next latch can hold the result
    assign start = (state_q == S_IDLE) && !in_link.empty && out_link.empty;

    assign in_link.rd   = start;
    assign lookup_req_o = start;
    // key comes straight from the latch, table answers next cycle
    assign lookup_idx_o = TBL_IDX_W'(in_link.rd_hdr[KEY_OFF]);

    always_comb begin
        hdr_rewr = hdr_q;
        if (entry_i.entry.valid) begin
            hdr_rewr[entry_i.entry.set_off] = entry_i.entry.set_val;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE: begin
                if (start) begin
                    state_d = S_WAIT;
                end
            end
            S_WAIT: begin
                state_d = S_WRITE;
            end
            S_WRITE: begin
                state_d = S_IDLE;
            end
            default: begin
                state_d = S_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= S_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // capture on read, rewrite when the entry is back
    always_ff @(posedge clk) begin
        if (start) begin
            hdr_q <= in_link.rd_hdr;
        end else if (state_q == S_WAIT) begin
            hdr_q <= hdr_rewr;
        end
    end

    assign out_link.wr  = (state_q == S_WRITE);
    assign out_link.hdr = hdr_q;

endmodule

/* rtl/hdr_latch.sv */
`timescale 1ns/1ps

module hdr_latch import switch_pkg::*; (
    input logic       clk,
    input logic       rst_n_i,
    hdr_link_if.latch link
);

    logic full_q;
    hdr_t hdr_q;
    logic load;

    // a write while full is dropped
    assign load = link.wr && !full_q;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            full_q <= 1'b0;
        end else if (load) begin
            full_q <= 1'b1;
        end else if (link.rd && full_q) begin
            full_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            hdr_q <= link.hdr;
        end
    end

    assign link.empty  = ~full_q;
    assign link.rd_hdr = hdr_q;

endmodule

/* rtl/hdr_link_if.sv */
`timescale 1ns/1ps

interface hdr_link_if import switch_pkg::*; ();

    logic wr;
    // header offered on a write
    hdr_t hdr;
    logic rd;
    logic empty;
    // header held by the latch
    hdr_t rd_hdr;

    modport producer (
        output wr,
        output hdr,
        input  empty
    );

    modport latch (
        input  wr,
        input  hdr,
        input  rd,
        output empty,
        output rd_hdr
    );

    modport consumer (
        output rd,
        input  rd_hdr,
        input  empty
    );

endinterface

/* rtl/flow_pkg.sv */
package flow_pkg;

    import switch_pkg::*;

    localparam int unsigned DATA_W      = 32;
    localparam int unsigned TBL_IDX_W   = 8;
    localparam int unsigned CTRL_ADDR_W = TBL_IDX_W + 1;

    // bits between the valid flag and set_off
    localparam int unsigned RSVD_W = DATA_W - 1 - $bits(hdr_idx_t) - BYTE_W;

    // raw view for the controller, entry view for the stages
    typedef union packed {
        logic [DATA_W-1:0] raw;
        struct packed {
            logic              valid;
            logic [RSVD_W-1:0] rsvd;
            hdr_idx_t          set_off;
            logic [BYTE_W-1:0] set_val;
        } entry;
    } flow_word_t;

endpackage

/* rtl/switch_pkg.sv */
package switch_pkg;

    // header geometry
    localparam int unsigned BYTE_W  = 8;
    localparam int unsigned HDR_LEN = 16;

    // byte 0 sits in the most significant slot
    typedef logic [0:HDR_LEN-1][BYTE_W-1:0] hdr_t;

    // byte position inside a header
    typedef logic [$clog2(HDR_LEN)-1:0] hdr_idx_t;

endpackage
